// ==== exception_unit.f ====
verilog/cp0_pkg.sv
verilog/exc_pkg.sv
verilog/cp0_if.sv
verilog/exc_prioritizer.sv
verilog/cp0_timer.sv
verilog/cp0_regs.sv
verilog/exception_unit.sv
sim/exception_unit_asserts.sv
sim/exception_unit_tb.sv

// ==== sim/exception_unit_tb.sv ====
`timescale 1ns/1ps

module exception_unit_tb
    import cp0_pkg::*, exc_pkg::*;
();

    localparam int num_tests       = 6;
    localparam int max_test_cycles = 400;

    logic        clk = 1'b0;
    logic        reset;
    stage_req_t  fetch_req;
    stage_req_t  decode_req;
    stage_req_t  exec_req;
    stage_req_t  mem_req;
    logic [5:0]  hw_int;
    logic        mtc0_wen;
    logic [4:0]  mtc0_num;
    logic [1:0]  mtc0_sel;
    logic [31:0] mtc0_data;
    logic [4:0]  rd_num;
    logic [31:0] rdata;
    logic        exception_now;
    logic        eret_now;
    logic [3:0]  flush;
    logic [31:0] redirect_pc;

    // reference cp0 state.
    logic        m_ie;
    logic        m_exl;
    logic [7:0]  m_im;
    logic [7:0]  m_ip;
    logic        m_bd;
    logic [4:0]  m_code;
    logic [31:0] m_epc;
    logic [31:0] m_bva;
    logic [31:0] m_count;
    logic [31:0] m_compare;
    logic        m_ti;
    logic        m_half;
    logic        m_block;
    logic        epc_known = 1'b0;
    logic        bva_known = 1'b0;

    string       cur_test = "reset";
    int          test_errs = 0;
    int          total_errs = 0;
    int          tests_failed = 0;
    logic [31:0] rng = 32'd13887;

    always #2 clk = ~clk;

    exception_unit dut_i (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic [31:0] rand32();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic exc_code_t pick_code(input logic [2:0] k);
        case (k)
            3'd0:    return exc_adel;
            3'd1:    return exc_ades;
            3'd2:    return exc_sys;
            3'd3:    return exc_bp;
            3'd4:    return exc_ri;
            3'd5:    return exc_ov;
            default: return exc_int;  // clean instruction.
        endcase
    endfunction

    function automatic stage_req_t make_req(input logic v, input exc_code_t code,
                                            input logic [31:0] pc, input logic ds,
                                            input logic [31:0] bva);
        stage_req_t r;
        r.valid      = v;
        r.code       = code;
        r.pc         = pc;
        r.delay_slot = ds;
        r.badvaddr   = bva;
        return r;
    endfunction

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic stage_req_t ref_take();
        stage_req_t st [4];
        stage_req_t t;
        st[0] = mem_req;
        st[1] = exec_req;
        st[2] = decode_req;
        st[3] = fetch_req;
        t = '0;
        for (int i = 0; i < 4; i++) begin
            if (!t.valid && st[i].valid && st[i].code != exc_int) begin
                t = st[i];
            end
        end
        if (m_ie && !m_exl && |(m_ip & m_im) && mem_req.valid && !m_block) begin
            t      = mem_req;  // interrupt rides on the mem instruction.
            t.code = exc_int;
        end
        return t;
    endfunction

    function automatic logic [31:0] ref_read(input logic [4:0] num);
        logic [31:0] w;
        w = '0;
        case (num)
            reg_count:    w = m_count;
            reg_compare:  w = m_compare;
            reg_status: begin
                w[0]     = m_ie;
                w[1]     = m_exl;
                w[15:8]  = m_im;
                w[22]    = 1'b1;  // bev.
            end
            reg_cause: begin
                w[6:2]   = m_code;
                w[15:8]  = m_ip;
                w[30]    = m_ti;
                w[31]    = m_bd;
            end
            reg_epc:      w = m_epc;
            reg_badvaddr: w = m_bva;
            default:      w = '0;
        endcase
        return w;
    endfunction

    task automatic model_step(input stage_req_t t);
        logic exc_now;
        logic ert;
        logic wr_ok;
        logic ti_n;
        exc_now = t.valid && t.code != eret_code;
        ert     = t.valid && t.code == eret_code;
        wr_ok   = mtc0_wen && mtc0_sel == 2'd0;
        if (reset) begin
            {m_ie, m_exl, m_im, m_ip, m_bd, m_code} = '0;
            m_half    = 1'b1;
            m_count   = '0;
            m_compare = 32'hffff_ffff;
            m_ti      = 1'b0;
            m_block   = 1'b0;
        end else begin
            ti_n = m_ti;
            if (wr_ok && mtc0_num == reg_compare) begin
                ti_n = 1'b0;
            end else if (m_count == m_compare) begin
                ti_n = 1'b1;
            end
            if (wr_ok && mtc0_num == reg_count) begin
                m_count = mtc0_data;
            end else if (m_half) begin
                m_count = m_count + 32'd1;
            end
            m_half = !m_half;
            if (wr_ok && mtc0_num == reg_compare) begin
                m_compare = mtc0_data;
            end
            m_ip[7:2] = {hw_int[5] | m_ti, hw_int[4:0]};
            if (wr_ok && mtc0_num == reg_cause) begin
                m_ip[1:0] = mtc0_data[9:8];
            end
            m_ti = ti_n;
            if (exc_now) begin
                m_code = t.code;
                if (t.code == exc_adel || t.code == exc_ades) begin
                    m_bva     = t.badvaddr;
                    bva_known = 1'b1;
                end
            end
            if (exc_now && !m_exl) begin
                m_bd      = t.delay_slot;
                m_epc     = t.delay_slot ? t.pc - 32'd4 : t.pc;
                epc_known = 1'b1;
            end else if (wr_ok && mtc0_num == reg_epc) begin
                m_epc     = mtc0_data;
                epc_known = 1'b1;
            end
            if (ert) begin
                m_exl = 1'b0;
            end else if (exc_now) begin
                m_exl = 1'b1;
            end else if (wr_ok && mtc0_num == reg_status) begin
                {m_ie, m_exl, m_im} = {mtc0_data[0], mtc0_data[1], mtc0_data[15:8]};
            end
            m_block = t.valid;
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("Mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    // compare in mid cycle, then advance the model to the next edge.
    always @(negedge clk) begin : compare_proc
        stage_req_t t;
        logic       exp_exc;
        logic       exp_eret;
        t        = ref_take();
        exp_exc  = t.valid && t.code != eret_code;
        exp_eret = t.valid && t.code == eret_code;
        if (reset === 1'b0) begin
            check_value("exception_now", exp_exc, exception_now);
            check_value("eret_now", exp_eret, eret_now);
            check_value("flush", (exp_exc || exp_eret) ? 32'hf : 32'h0, flush);
            if (t.valid) begin
                check_value("redirect_pc", exp_eret ? m_epc : 32'hbfc0_0380, redirect_pc);
            end
            if (!(rd_num == reg_epc && !epc_known) && !(rd_num == reg_badvaddr && !bva_known)) begin
                check_value("rdata", ref_read(rd_num), rdata);
            end
        end
        model_step(t);
    end

    // ----------------------------------------
    // stimulus helpers
    // ----------------------------------------
    task automatic write_cp0(input logic [4:0] num, input logic [31:0] data);
        @(posedge clk);
        mtc0_wen  <= 1'b1;
        mtc0_num  <= num;
        mtc0_data <= data;
        @(posedge clk);
        mtc0_wen  <= 1'b0;
    endtask

    task automatic read_reg(input logic [4:0] num);
        @(posedge clk);
        rd_num <= num;
        @(posedge clk);
    endtask

    task automatic issue(input stage_req_t f, input stage_req_t d,
                         input stage_req_t e, input stage_req_t m);
        @(posedge clk);
        fetch_req  <= f;
        decode_req <= d;
        exec_req   <= e;
        mem_req    <= m;
        @(posedge clk);
        fetch_req  <= '0;
        decode_req <= '0;
        exec_req   <= '0;
        mem_req    <= '0;
    endtask

    task automatic do_eret();
        issue('0, '0, '0, make_req(1'b1, eret_code, 32'd0, 1'b0, 32'd0));
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            $display("%s: ok", cur_test);
        end else begin
            $display("%s: %0d errors", cur_test, test_errs);
            tests_failed++;
        end
        total_errs += test_errs;
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------
    task automatic test_oldest_wins();
        stage_req_t  r [4];
        logic [31:0] x;
        logic [31:0] pc;
        for (int n = 0; n < 20; n++) begin
            for (int s = 0; s < 4; s++) begin
                x     = rand32();
                pc    = rand32();
                r[s]  = make_req(x[0], pick_code(x[10:8]), {pc[31:2], 2'b00}, x[4], rand32());
            end
            issue(r[3], r[2], r[1], r[0]);
            read_reg(reg_cause);
            read_reg(reg_epc);
            do_eret();
        end
    endtask

    task automatic test_interrupts();
        int          polls;
        logic [31:0] pc;
        pc = rand32() & 32'hffff_fffc;
        write_cp0(reg_status, 32'h0000_8401);  // ie, im7 and im2.
        write_cp0(reg_compare, m_count + 32'd12);
        read_reg(reg_compare);
        read_reg(reg_count);
        read_reg(reg_cause);
        polls = 0;
        do begin
            @(negedge clk);
            polls++;
        end while (!(rdata[30] && rdata[15]) && polls < 200);
        if (polls >= 200) begin
            $display("%s: timer interrupt never showed up in Cause", cur_test);
            test_errs++;
        end
        issue('0, '0, '0, make_req(1'b1, exc_int, pc, 1'b0, 32'd0));
        write_cp0(reg_compare, 32'hffff_ffff);
        read_reg(reg_cause);
        do_eret();
        @(posedge clk);
        hw_int <= 6'b000001;
        read_reg(reg_cause);
        issue('0, '0, '0, make_req(1'b1, exc_int, pc + 32'd4, 1'b1, 32'd0));
        @(posedge clk);
        hw_int <= '0;
        do_eret();
    endtask

    initial begin : stimulus
        logic [31:0] pc;
        logic [31:0] a;
        reset      = 1'b1;
        fetch_req  = '0;
        decode_req = '0;
        exec_req   = '0;
        mem_req    = '0;
        hw_int     = '0;
        mtc0_wen   = 1'b0;
        mtc0_num   = '0;
        mtc0_sel   = '0;
        mtc0_data  = '0;
        rd_num     = reg_status;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        start_test("cp0_rw");
        write_cp0(reg_status, 32'hffff_ffff);
        read_reg(reg_status);
        write_cp0(reg_status, 32'h0);
        write_cp0(reg_epc, rand32());
        read_reg(reg_epc);
        @(posedge clk);
        mtc0_wen  <= 1'b1;  // nonzero select, no cp0 register.
        mtc0_num  <= reg_epc;
        mtc0_sel  <= 2'd1;
        mtc0_data <= rand32();
        @(posedge clk);
        mtc0_wen  <= 1'b0;
        mtc0_sel  <= 2'd0;
        write_cp0(reg_cause, 32'hffff_ffff);  // only ip1..0 sticks.
        read_reg(reg_cause);
        write_cp0(reg_cause, 32'h0);
        end_test();

        start_test("oldest_wins");
        test_oldest_wins();
        end_test();

        start_test("delay_slot");
        pc = rand32() & 32'hffff_fffc;
        issue('0, '0, make_req(1'b1, exc_sys, pc, 1'b1, 32'd0), '0);
        read_reg(reg_epc);
        issue(make_req(1'b1, exc_ri, pc + 32'd8, 1'b0, 32'd0), '0, '0, '0);
        read_reg(reg_cause);
        read_reg(reg_epc);
        do_eret();
        end_test();

        start_test("eret");
        issue('0, '0, '0, make_req(1'b1, exc_bp, pc, 1'b0, 32'd0));
        read_reg(reg_status);
        do_eret();
        read_reg(reg_cause);
        end_test();

        start_test("badvaddr");
        a = rand32();
        issue('0, '0, '0, make_req(1'b1, exc_adel, pc, 1'b0, a));
        read_reg(reg_badvaddr);
        do_eret();
        issue('0, '0, make_req(1'b1, exc_ades, pc, 1'b0, a ^ 32'h55aa), '0);
        read_reg(reg_badvaddr);
        do_eret();
        issue('0, make_req(1'b1, exc_ov, pc, 1'b0, rand32()), '0, '0);
        read_reg(reg_badvaddr);
        do_eret();
        end_test();

        start_test("interrupts");
        test_interrupts();
        end_test();

        repeat (2) @(posedge clk);
        $display("%0d tests run, %0d failed, %0d errors, %0d assertion failures",
                 num_tests, tests_failed, total_errs, dut_i.asserts_i.fail_count);
        if (tests_failed == 0 && dut_i.asserts_i.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        #((num_tests * max_test_cycles + 10) * 4);
        $display("watchdog expired before the tests finished");
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== sim/exception_unit_asserts.sv ====
`timescale 1ns/1ps

module exception_unit_asserts
    import cp0_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        exception_now,
    input logic        eret_now,
    input logic [3:0]  flush,
    input logic [31:0] redirect_pc
);

    int fail_count = 0;  // read by the testbench.

    flush_matches_redirect: assert property (@(posedge clk) disable iff (reset)
        (flush == 4'hf) == (exception_now || eret_now))
    else begin
        $error("flush is not all ones exactly when a redirect is raised");
        fail_count++;
    end

    vector_on_exception: assert property (@(posedge clk) disable iff (reset)
        exception_now |-> redirect_pc == exc_vector)
    else begin
        $error("redirect_pc is not the exception vector during an exception");
        fail_count++;
    end

    one_redirect_kind: assert property (@(posedge clk) disable iff (reset)
        !(exception_now && eret_now))
    else begin
        $error("exception_now and eret_now are high together");
        fail_count++;
    end

endmodule

bind exception_unit exception_unit_asserts asserts_i (
    .clk           (clk),
    .reset         (reset),
    .exception_now (exception_now),
    .eret_now      (eret_now),
    .flush         (flush),
    .redirect_pc   (redirect_pc)
);

// ==== verilog/exception_unit.sv ====
`timescale 1ns/1ps

module exception_unit
    import exc_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  stage_req_t  fetch_req,
    input  stage_req_t  decode_req,
    input  stage_req_t  exec_req,
    input  stage_req_t  mem_req,
    input  logic [5:0]  hw_int,
    input  logic        mtc0_wen,
    input  logic [4:0]  mtc0_num,
    input  logic [1:0]  mtc0_sel,
    input  logic [31:0] mtc0_data,
    input  logic [4:0]  rd_num,
    output logic [31:0] rdata,
    output logic        exception_now,
    output logic        eret_now,
    output logic [3:0]  flush,
    output logic [31:0] redirect_pc
);

    stage_req_t  stage_req [num_stages];
    logic [31:0] count;
    logic [31:0] compare;
    logic        timer_int;

    cp0_wr_if wr_bus ();
    exc_if    exc_bus ();

    assign stage_req[stage_fetch]  = fetch_req;
    assign stage_req[stage_decode] = decode_req;
    assign stage_req[stage_exec]   = exec_req;
    assign stage_req[stage_mem]    = mem_req;

    // core mtc0 onto the write bus.
    assign wr_bus.wen     = mtc0_wen;
    assign wr_bus.reg_num = mtc0_num;
    assign wr_bus.sel     = mtc0_sel;
    assign wr_bus.wdata   = mtc0_data;

    exc_prioritizer prio_i (
        .clk       (clk),
        .stage_req (stage_req),
        .exc       (exc_bus.prio)
    );

    cp0_timer timer_i (
        .clk       (clk),
        .reset     (reset),
        .wr        (wr_bus.sink),
        .count     (count),
        .compare   (compare),
        .timer_int (timer_int)
    );

    cp0_regs regs_i (
        .clk           (clk),
        .reset         (reset),
        .wr            (wr_bus.sink),
        .exc           (exc_bus.regs),
        .rd_num        (rd_num),
        .rdata         (rdata),
        .count         (count),
        .compare       (compare),
        .timer_int     (timer_int),
        .hw_int        (hw_int),
        .exception_now (exception_now),
        .eret_now      (eret_now),
        .flush         (flush),
        .redirect_pc   (redirect_pc)
    );

endmodule

// ==== verilog/cp0_regs.sv ====
`timescale 1ns/1ps

module cp0_regs
    import cp0_pkg::*, exc_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    cp0_wr_if.sink      wr,
    exc_if.regs         exc,
    input  logic [4:0]  rd_num,
    output logic [31:0] rdata,
    input  logic [31:0] count,
    input  logic [31:0] compare,
    input  logic        timer_int,
    input  logic [5:0]  hw_int,
    output logic        exception_now,
    output logic        eret_now,
    output logic [3:0]  flush,
    output logic [31:0] redirect_pc
);

    logic        status_ie_q;
    logic        status_exl_q;
    logic [7:0]  status_im;
    logic        cause_bd_q;
    logic [7:0]  cause_ip;
    exc_code_t   cause_exccode;
    logic [31:0] epc;
    logic [31:0] badvaddr;

    logic [31:0] status_word;
    logic [31:0] cause_word;
    logic [31:0] epc_next;
    logic        status_wr;
    logic        cause_wr;
    logic        epc_wr;
    logic        addr_fault;

    // ----------------------------------------
    // request decode
    // ----------------------------------------
    assign exception_now = exc.valid && !exc.eret;
    assign eret_now      = exc.valid && exc.eret;
    assign flush         = {num_stages{exception_now || eret_now}};
    assign redirect_pc   = eret_now ? epc : exc_vector;

    assign addr_fault = exception_now && (exc.code == exc_adel || exc.code == exc_ades);
    assign epc_next   = exc.delay_slot ? exc.pc - 32'd4 : exc.pc;

    assign status_wr = wr.wen && wr.sel == 2'd0 && wr.reg_num == reg_status;
    assign cause_wr  = wr.wen && wr.sel == 2'd0 && wr.reg_num == reg_cause;
    assign epc_wr    = wr.wen && wr.sel == 2'd0 && wr.reg_num == reg_epc;

    assign exc.int_pending = status_ie_q && !status_exl_q && |(cause_ip & status_im);

    // ----------------------------------------
    // status
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            status_ie_q  <= 1'b0;
            status_exl_q <= 1'b0;
            status_im    <= 8'd0;
        end else if (eret_now) begin
            status_exl_q <= 1'b0;
        end else if (exception_now) begin
            status_exl_q <= 1'b1;
        end else if (status_wr) begin
            status_ie_q  <= wr.wdata[status_ie];
            status_exl_q <= wr.wdata[status_exl];
            status_im    <= wr.wdata[status_im_hi:status_im_lo];
        end
    end

    // ----------------------------------------
    // cause
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            cause_bd_q    <= 1'b0;
            cause_exccode <= exc_int;
        end else if (exception_now) begin
            cause_exccode <= exc.code;
            if (!status_exl_q) begin
                cause_bd_q <= exc.delay_slot;  // nested fault keeps bd.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cause_ip <= 8'd0;
        end else begin
            cause_ip[7]   <= hw_int[5] | timer_int;
            cause_ip[6:2] <= hw_int[4:0];
            if (cause_wr) begin
                cause_ip[1:0] <= wr.wdata[cause_ip_lo +: 2];  // software bits.
            end
        end
    end

    // ----------------------------------------
    // epc and badvaddr
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (exception_now && !status_exl_q) begin
            epc <= epc_next;
        end else if (epc_wr) begin
            epc <= wr.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (addr_fault) begin
            badvaddr <= exc.badvaddr;
        end
    end

    // ----------------------------------------
    // mfc0 read
    // ----------------------------------------
    always_comb begin
        status_word = '0;
        status_word[status_ie]                 = status_ie_q;
        status_word[status_exl]                = status_exl_q;
        status_word[status_im_hi:status_im_lo] = status_im;
        status_word[status_bev]                = 1'b1;
    end

    always_comb begin
        cause_word = '0;
        cause_word[cause_exc_hi:cause_exc_lo] = cause_exccode;
        cause_word[cause_ip_hi:cause_ip_lo]   = cause_ip;
        cause_word[cause_ti]                  = timer_int;
        cause_word[cause_bd]                  = cause_bd_q;
    end

    always_comb begin
        case (rd_num)
            reg_count:    rdata = count;
            reg_compare:  rdata = compare;
            reg_status:   rdata = status_word;
            reg_cause:    rdata = cause_word;
            reg_epc:      rdata = epc;
            reg_badvaddr: rdata = badvaddr;
            default:      rdata = 32'd0;
        endcase
    end

endmodule

// ==== verilog/cp0_timer.sv ====
`timescale 1ns/1ps

module cp0_timer
    import cp0_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    cp0_wr_if.sink      wr,
    output logic [31:0] count,
    output logic [31:0] compare,
    output logic        timer_int
);

    logic half_q;
    logic count_wr;
    logic compare_wr;

    assign count_wr   = wr.wen && wr.sel == 2'd0 && wr.reg_num == reg_count;
    assign compare_wr = wr.wen && wr.sel == 2'd0 && wr.reg_num == reg_compare;

    // count runs at half the core clock.
    always_ff @(posedge clk) begin
        if (reset) begin
            half_q <= 1'b1;
        end else begin
            half_q <= ~half_q;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= 32'd0;
        end else if (count_wr) begin
            count <= wr.wdata;
        end else if (half_q) begin
            count <= count + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            compare <= 32'hffff_ffff;  // far from count after reset.
        end else if (compare_wr) begin
            compare <= wr.wdata;
        end
    end

    // sticky until compare is rewritten.
    always_ff @(posedge clk) begin
        if (reset) begin
            timer_int <= 1'b0;
        end else if (compare_wr) begin
            timer_int <= 1'b0;
        end else if (count == compare) begin
            timer_int <= 1'b1;
        end
    end

endmodule

// ==== verilog/exc_prioritizer.sv ====
`timescale 1ns/1ps

module exc_prioritizer
    import exc_pkg::*;
(
    input  logic       clk,
    input  stage_req_t stage_req [num_stages],
    exc_if.prio        exc
);

    stage_req_t pick;
    logic       found;
    logic       int_take;
    logic       int_block_q;

    // ----------------------------------------
    // oldest raising stage
    // ----------------------------------------
    always_comb begin
        pick  = '0;
        found = 1'b0;
        for (int i = num_stages - 1; i >= 0; i--) begin
            if (!found && stage_req[i].valid && stage_req[i].code != exc_int) begin
                pick  = stage_req[i];
                found = 1'b1;
            end
        end
    end

    // slot after a redirect holds flushed work.
    always_ff @(posedge clk) begin
        int_block_q <= exc.valid;
    end

    assign int_take = exc.int_pending && stage_req[stage_mem].valid && !int_block_q;

    // ----------------------------------------
    // drive the taken request
    // ----------------------------------------
    always_comb begin
        if (int_take) begin
            exc.valid      = 1'b1;
            exc.eret       = 1'b0;
            exc.code       = exc_int;
            exc.pc         = stage_req[stage_mem].pc;  // interrupt lands on mem.
            exc.delay_slot = stage_req[stage_mem].delay_slot;
            exc.badvaddr   = stage_req[stage_mem].badvaddr;
        end else begin
            exc.valid      = found;
            exc.eret       = found && (pick.code == eret_code);
            exc.code       = pick.code;
            exc.pc         = pick.pc;
            exc.delay_slot = pick.delay_slot;
            exc.badvaddr   = pick.badvaddr;
        end
    end

endmodule

// ==== verilog/cp0_if.sv ====
`timescale 1ns/1ps

// mtc0 write port.
interface cp0_wr_if;
    logic        wen;
    logic [4:0]  reg_num;
    logic [1:0]  sel;
    logic [31:0] wdata;

    modport source (
        output wen, reg_num, sel, wdata
    );

    modport sink (
        input wen, reg_num, sel, wdata
    );
endinterface

// taken request, prioritizer to cp0 registers.
interface exc_if;
    logic                valid;
    logic                eret;
    exc_pkg::exc_code_t  code;
    logic [31:0]         pc;
    logic                delay_slot;
    logic [31:0]         badvaddr;
    logic                int_pending;  // back from cp0_regs.

    modport prio (
        output valid, eret, code, pc, delay_slot, badvaddr,
        input  int_pending
    );

    modport regs (
        input  valid, eret, code, pc, delay_slot, badvaddr,
        output int_pending
    );
endinterface

// ==== verilog/exc_pkg.sv ====
package exc_pkg;

    typedef enum logic [4:0] {
        exc_int   = 5'd0,  // also marks a clean instruction.
        exc_adel  = 5'd4,
        exc_ades  = 5'd5,
        exc_sys   = 5'd8,
        exc_bp    = 5'd9,
        exc_ri    = 5'd10,
        exc_ov    = 5'd12,
        eret_code = 5'd31
    } exc_code_t;

    localparam int num_stages = 4;

    // ----------------------------------------
    // stage slots, oldest has the highest index
    // ----------------------------------------
    localparam int stage_fetch  = 0;
    localparam int stage_decode = 1;
    localparam int stage_exec   = 2;
    localparam int stage_mem    = 3;

    // A valid entry with code exc_int is an instruction that raises
    // nothing itself. In the memory stage it is what an interrupt uses.
    typedef struct packed {
        logic        valid;
        exc_code_t   code;
        logic [31:0] pc;
        logic        delay_slot;
        logic [31:0] badvaddr;
    } stage_req_t;

endpackage

// ==== verilog/cp0_pkg.sv ====
package cp0_pkg;

    // ----------------------------------------
    // cp0 register numbers
    // ----------------------------------------
    localparam logic [4:0] reg_badvaddr = 5'd8;
    localparam logic [4:0] reg_count    = 5'd9;
    localparam logic [4:0] reg_compare  = 5'd11;
    localparam logic [4:0] reg_status   = 5'd12;
    localparam logic [4:0] reg_cause    = 5'd13;
    localparam logic [4:0] reg_epc      = 5'd14;

    // general exception entry, bev fixed at 1.
    localparam logic [31:0] exc_vector = 32'hbfc0_0380;

    // ----------------------------------------
    // status fields
    // ----------------------------------------
    localparam int status_ie    = 0;
    localparam int status_exl   = 1;
    localparam int status_im_lo = 8;
    localparam int status_im_hi = 15;
    localparam int status_bev   = 22;

    // ----------------------------------------
    // cause fields
    // ----------------------------------------
    localparam int cause_exc_lo = 2;
    localparam int cause_exc_hi = 6;
    localparam int cause_ip_lo  = 8;
    localparam int cause_ip_hi  = 15;
    localparam int cause_ti     = 30;
    localparam int cause_bd     = 31;

endpackage
